// File: Makefile
# Verilator simulation of the LM80C bus glue

VERILATOR ?= verilator
TOP       ?= tb_lm80c_bus
FILELIST  ?= lm80c_bus.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

// File: lm80c_audio_dac.sv
//////////////////////////////////////////////////////////////
// LM80C audio DAC
// Mono sum of the three PSG channels into a first-order
// sigma-delta modulator, one bit out per clock
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lm80c_audio_dac (
	input  logic             CLOCK,
	input  logic             arst_n_i,
	input  lm80c_pkg::byte_t chan_a_i,
	input  lm80c_pkg::byte_t chan_b_i,
	input  lm80c_pkg::byte_t chan_c_i,
	output logic             dac_o
);

	logic [9:0]  chan_sum;                   // Up to 3 * 255
	logic [15:0] dac_in;
	logic [15:0] acc;
	logic [16:0] acc_next;                   // Bit 16 is the carry

	assign chan_sum = {2'b00, chan_a_i} + {2'b00, chan_b_i} + {2'b00, chan_c_i};
	assign dac_in   = {chan_sum, 6'b000000}; // Left aligned
	assign acc_next = {1'b0, acc} + {1'b0, dac_in};

	// Ones density on dac_o is dac_in / 2^16
	always_ff @(posedge CLOCK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			acc   <= '0;
			dac_o <= 1'b0;
		end else begin
			acc   <= acc_next[15:0];
			dac_o <= acc_next[16];
		end
	end

endmodule

// File: lm80c_boot_check.sv
//////////////////////////////////////////////////////////////
// LM80C boot checker
// After reset release, reads RAM bytes 0..3, compares them
// with the firmware signature and shows the result on the LED
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lm80c_boot_check (
	input  logic                 CLOCK,
	input  logic                 arst_n_i,
	input  logic                 run_i,      // CPU out of reset
	input  lm80c_pkg::byte_t     ram_q_i,
	input  logic                 led_wr_i,
	input  lm80c_pkg::byte_t     led_data_i,
	output logic                 busy_o,
	output lm80c_pkg::cpu_addr_t addr_o,
	output logic                 led_o
);

	import lm80c_pkg::*;

	boot_state_t state;
	logic        run_q;
	logic [2:0]  step;                       // 0..3 address, 1..4 check
	logic [2:0]  match_cnt;
	logic [1:0]  chk_idx;
	logic        sig_hit;

	assign busy_o  = (state == READING);
	assign addr_o  = {14'd0, step[1:0]};
	assign chk_idx = step[1:0] - 2'd1;       // Data lags the address by one
	assign sig_hit = (ram_q_i == BOOT_SIGNATURE[chk_idx]);

	always_ff @(posedge CLOCK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state     <= WAIT_RUN;
			run_q     <= 1'b0;
			step      <= '0;
			match_cnt <= '0;
			led_o     <= 1'b0;
		end else begin
			run_q <= run_i;
			if (!run_i) begin
				state <= WAIT_RUN;            // Rearm on every reset
			end else begin
				case (state)
					WAIT_RUN: if (!run_q) begin  // First cycle out of reset
						state     <= READING;
						step      <= '0;
						match_cnt <= '0;
					end
					READING: begin
						step <= step + 3'd1;
						if (step != 3'd0 && sig_hit)
							match_cnt <= match_cnt + 3'd1;
						if (step == 3'd4) begin
							state <= DONE;
							led_o <= (match_cnt + {2'b00, sig_hit}) == 3'd4;
						end
					end
					DONE: if (led_wr_i && led_data_i[0])
						led_o <= ~led_o;         // Debug LED port
					default: state <= WAIT_RUN;
				endcase
			end
		end
	end

endmodule

// File: lm80c_bus.f
lm80c_pkg.sv
lm80c_io_decode.sv
lm80c_mem_arbiter.sv
lm80c_sysram.sv
lm80c_eraser.sv
lm80c_boot_check.sv
lm80c_audio_dac.sv
lm80c_bus.sv
tb_lm80c_bus.sv

// File: lm80c_bus.sv
//////////////////////////////////////////////////////////////
// LM80C system-bus glue, top level
// I/O decode, system RAM and its masters, boot check,
// audio DAC, and CPU reset and wait generation
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lm80c_bus #(
	parameter int RAM_AW = 16
) (
	input  logic                 CLOCK,
	input  logic                 arst_n_i,
	// Z80 side
	input  lm80c_pkg::cpu_addr_t cpu_addr_i,
	input  lm80c_pkg::byte_t     cpu_data_i,
	input  logic                 cpu_rd_n_i,
	input  logic                 cpu_wr_n_i,
	input  logic                 cpu_mreq_n_i,
	input  logic                 cpu_iorq_n_i,
	output lm80c_pkg::byte_t     cpu_din_o,
	output logic                 cpu_reset_n_o,
	output logic                 cpu_wait_n_o,
	// Peripherals
	input  lm80c_pkg::byte_t     ctc_dout_i,
	input  lm80c_pkg::byte_t     vdp_dout_i,
	input  lm80c_pkg::byte_t     psg_dout_i,
	output logic                 ctc_ce_n_o,
	output logic                 vdp_csr_n_o,
	output logic                 vdp_csw_n_o,
	output logic                 psg_bdir_o,
	output logic                 psg_bc_o,
	// External loader
	input  logic                 load_active_i,
	input  logic                 load_wr_i,
	input  logic [RAM_AW-1:0]    load_addr_i,
	input  lm80c_pkg::byte_t     load_data_i,
	input  logic                 load_done_i,
	// Misc
	input  logic                 erase_i,
	input  logic                 reset_key_i,
	input  lm80c_pkg::byte_t     audio_a_i,
	input  lm80c_pkg::byte_t     audio_b_i,
	input  lm80c_pkg::byte_t     audio_c_i,
	output logic                 led_o,
	output logic                 audio_o
);

	import lm80c_pkg::*;

	logic              erase_busy, boot_busy, led_wr;
	logic [RAM_AW-1:0] erase_addr, ram_addr;
	cpu_addr_t         boot_addr;
	byte_t             ram_data, ram_q;
	logic              ram_we;

	// Reset until loaded, or while the key is down
	assign cpu_reset_n_o = load_done_i & ~reset_key_i;
	// Stall the CPU whenever another master owns the RAM
	assign cpu_wait_n_o  = load_done_i & ~(load_active_i | erase_busy | boot_busy);

	lm80c_io_decode io_decode_i (
		.CLOCK, .arst_n_i, .cpu_addr_i, .cpu_data_i, .cpu_rd_n_i, .cpu_wr_n_i,
		.cpu_mreq_n_i, .cpu_iorq_n_i, .ram_q_i(ram_q), .ctc_dout_i, .vdp_dout_i,
		.psg_dout_i, .cpu_din_o, .ctc_ce_n_o, .vdp_csr_n_o, .vdp_csw_n_o,
		.psg_bdir_o, .psg_bc_o, .led_wr_o(led_wr)
	);

	lm80c_mem_arbiter #(.RAM_AW(RAM_AW)) mem_arbiter_i (
		.load_active_i, .load_wr_i, .load_addr_i, .load_data_i,
		.erase_busy_i(erase_busy), .erase_addr_i(erase_addr),
		.boot_busy_i(boot_busy), .boot_addr_i(boot_addr),
		.cpu_addr_i, .cpu_data_i, .cpu_wr_n_i, .cpu_mreq_n_i,
		.ram_addr_o(ram_addr), .ram_data_o(ram_data), .ram_we_o(ram_we)
	);

	lm80c_sysram #(.RAM_AW(RAM_AW)) sysram_i (
		.CLOCK, .addr_i(ram_addr), .data_i(ram_data), .we_i(ram_we), .q_o(ram_q)
	);

	lm80c_eraser #(.RAM_AW(RAM_AW)) eraser_i (
		.CLOCK, .arst_n_i, .trigger_i(erase_i), .busy_o(erase_busy), .addr_o(erase_addr)
	);

	lm80c_boot_check boot_check_i (
		.CLOCK, .arst_n_i, .run_i(cpu_reset_n_o), .ram_q_i(ram_q),
		.led_wr_i(led_wr), .led_data_i(cpu_data_i),
		.busy_o(boot_busy), .addr_o(boot_addr), .led_o
	);

	lm80c_audio_dac audio_dac_i (
		.CLOCK, .arst_n_i, .chan_a_i(audio_a_i), .chan_b_i(audio_b_i),
		.chan_c_i(audio_c_i), .dac_o(audio_o)
	);

endmodule

// File: lm80c_eraser.sv
//////////////////////////////////////////////////////////////
// LM80C memory eraser
// On a trigger rising edge, walks the whole RAM once
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lm80c_eraser #(
	parameter int RAM_AW = 16
) (
	input  logic              CLOCK,
	input  logic              arst_n_i,
	input  logic              trigger_i,
	output logic              busy_o,        // Also the write enable
	output logic [RAM_AW-1:0] addr_o
);

	import lm80c_pkg::*;

	erase_state_t state;
	logic         trig_q;

	assign busy_o = (state == ERASING);

	always_ff @(posedge CLOCK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state  <= IDLE;
			trig_q <= 1'b0;
			addr_o <= '0;
		end else begin
			trig_q <= trigger_i;
			case (state)
				IDLE: if (trigger_i && !trig_q) begin
					state  <= ERASING;
					addr_o <= '0;
				end
				ERASING: begin
					addr_o <= addr_o + RAM_AW'(1);
					if (&addr_o)                 // Last address written
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: lm80c_io_decode.sv
//////////////////////////////////////////////////////////////
// LM80C I/O decoder
// Registered port group selects, peripheral strobes, LED
// port write pulse and the CPU read-data multiplexer
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lm80c_io_decode (
	input  logic              CLOCK,
	input  logic              arst_n_i,
	input  lm80c_pkg::cpu_addr_t cpu_addr_i,
	input  lm80c_pkg::byte_t  cpu_data_i,
	input  logic              cpu_rd_n_i,
	input  logic              cpu_wr_n_i,
	input  logic              cpu_mreq_n_i,
	input  logic              cpu_iorq_n_i,
	input  lm80c_pkg::byte_t  ram_q_i,       // System RAM read data
	input  lm80c_pkg::byte_t  ctc_dout_i,
	input  lm80c_pkg::byte_t  vdp_dout_i,
	input  lm80c_pkg::byte_t  psg_dout_i,
	output lm80c_pkg::byte_t  cpu_din_o,
	output logic              ctc_ce_n_o,
	output logic              vdp_csr_n_o,
	output logic              vdp_csw_n_o,
	output logic              psg_bdir_o,
	output logic              psg_bc_o,
	output logic              led_wr_o       // One cycle per LED port write
);

	import lm80c_pkg::*;

	logic      io_cycle;
	port_grp_t grp;
	logic      led_hit;
	logic      led_hit_q;                    // Previous led_hit, for the edge
	logic      pio_sel, ctc_sel, sio_sel, vdp_sel, psg_sel;

	assign io_cycle = ~cpu_iorq_n_i & cpu_mreq_n_i;  // I/O, not interrupt ack
	assign grp      = cpu_addr_i[7:4];
	// Odd byte written to the LED port
	assign led_hit  = io_cycle & ~cpu_wr_n_i & (grp == PORT_LED) & cpu_data_i[0];

	always_ff @(posedge CLOCK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pio_sel     <= 1'b0;
			ctc_sel     <= 1'b0;
			sio_sel     <= 1'b0;
			vdp_sel     <= 1'b0;
			psg_sel     <= 1'b0;
			ctc_ce_n_o  <= 1'b1;
			vdp_csr_n_o <= 1'b1;
			vdp_csw_n_o <= 1'b1;
			psg_bdir_o  <= 1'b0;
			psg_bc_o    <= 1'b0;
			led_hit_q   <= 1'b0;
			led_wr_o    <= 1'b0;
			cpu_din_o   <= '0;
		end else begin
			// Group selects, one cycle after the address
			pio_sel <= io_cycle & (grp == PORT_PIO);
			ctc_sel <= io_cycle & (grp == PORT_CTC);
			sio_sel <= io_cycle & (grp == PORT_SIO);
			vdp_sel <= io_cycle & (grp == PORT_VDP);
			psg_sel <= io_cycle & (grp == PORT_PSG);

			// Peripheral strobes, same cycle as the selects
			ctc_ce_n_o  <= ~(io_cycle & (grp == PORT_CTC));
			vdp_csr_n_o <= ~(io_cycle & (grp == PORT_VDP) & ~cpu_rd_n_i);
			vdp_csw_n_o <= ~(io_cycle & (grp == PORT_VDP) & ~cpu_wr_n_i);
			psg_bdir_o  <= io_cycle & (grp == PORT_PSG) & ~cpu_wr_n_i;
			psg_bc_o    <= io_cycle & (grp == PORT_PSG) & ~cpu_addr_i[0];  // Even port latches

			led_hit_q <= led_hit;
			led_wr_o  <= led_hit & ~led_hit_q;   // Rising edge only

			// Read mux, a cycle behind the selects
			if (pio_sel)      cpu_din_o <= 8'h00;     // No PIO in this build
			else if (ctc_sel) cpu_din_o <= ctc_dout_i;
			else if (sio_sel) cpu_din_o <= 8'h00;     // No SIO either
			else if (vdp_sel) cpu_din_o <= vdp_dout_i;
			else if (psg_sel) cpu_din_o <= psg_dout_i;
			else              cpu_din_o <= ram_q_i;   // Memory read
		end
	end

endmodule

// File: lm80c_mem_arbiter.sv
//////////////////////////////////////////////////////////////
// LM80C system RAM arbiter
// Fixed-priority choice of loader, eraser, boot checker or
// CPU, with the low 32 KiB write-protected for the CPU
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lm80c_mem_arbiter #(
	parameter int RAM_AW = 16                // RAM address width, at most 16
) (
	input  logic                 load_active_i,
	input  logic                 load_wr_i,
	input  logic [RAM_AW-1:0]    load_addr_i,
	input  lm80c_pkg::byte_t     load_data_i,
	input  logic                 erase_busy_i,
	input  logic [RAM_AW-1:0]    erase_addr_i,
	input  logic                 boot_busy_i,
	input  lm80c_pkg::cpu_addr_t boot_addr_i,
	input  lm80c_pkg::cpu_addr_t cpu_addr_i,
	input  lm80c_pkg::byte_t     cpu_data_i,
	input  logic                 cpu_wr_n_i,
	input  logic                 cpu_mreq_n_i,
	output logic [RAM_AW-1:0]    ram_addr_o,
	output lm80c_pkg::byte_t     ram_data_o,
	output logic                 ram_we_o
);

	import lm80c_pkg::*;

	logic cpu_we;

	// A15 clear is ROM, the CPU may only read it
	assign cpu_we = ~cpu_wr_n_i & ~cpu_mreq_n_i & cpu_addr_i[15];

	always_comb begin
		if (load_active_i) begin             // Loader owns the bus
			ram_addr_o = load_addr_i;
			ram_data_o = load_data_i;
			ram_we_o   = load_wr_i;
		end else if (erase_busy_i) begin
			ram_addr_o = erase_addr_i;
			ram_data_o = ERASE_VALUE;
			ram_we_o   = erase_busy_i;       // Writes every busy cycle
		end else if (boot_busy_i) begin      // Read only
			ram_addr_o = boot_addr_i[RAM_AW-1:0];
			ram_data_o = cpu_data_i;
			ram_we_o   = 1'b0;
		end else begin
			ram_addr_o = cpu_addr_i[RAM_AW-1:0];
			ram_data_o = cpu_data_i;
			ram_we_o   = cpu_we;
		end
	end

endmodule

// File: lm80c_pkg.sv
//////////////////////////////////////////////////////////////
// LM80C bus package
// Bus widths, I/O port group codes, boot signature, erase
// value and FSM state types for the system-bus glue
//////////////////////////////////////////////////////////////

package lm80c_pkg;

	// Z80 bus types
	typedef logic [15:0] cpu_addr_t;     // Full Z80 address
	typedef logic [7:0]  byte_t;         // Data byte
	typedef logic [3:0]  port_grp_t;     // I/O group, address bits 7..4

	// Port groups as wired on the LM80C board
	localparam port_grp_t PORT_PIO = 4'h0;  // Ports 0x00..0x0F
	localparam port_grp_t PORT_CTC = 4'h1;  // Ports 0x10..0x1F
	localparam port_grp_t PORT_SIO = 4'h2;
	localparam port_grp_t PORT_VDP = 4'h3;
	localparam port_grp_t PORT_PSG = 4'h4;
	localparam port_grp_t PORT_LED = 4'h7;  // Debug LED at 0x70

	// Expected first bytes of the firmware image
	// Index 0 is address 0, i.e. DI then JP 025A
	localparam byte_t [3:0] BOOT_SIGNATURE = {8'h02, 8'h5A, 8'hC3, 8'hF3};

	localparam byte_t ERASE_VALUE = 8'h00;  // Fill byte for the RAM eraser

	// Eraser FSM
	typedef enum logic {
		IDLE,
		ERASING
	} erase_state_t;

	// Boot checker FSM
	typedef enum logic [1:0] {
		WAIT_RUN,   // Held in reset, waiting for release
		READING,    // Walking addresses 0..3
		DONE        // Result on the LED, port writes toggle it
	} boot_state_t;

endpackage

// File: lm80c_sysram.sv
//////////////////////////////////////////////////////////////
// LM80C system RAM
// Single-port byte RAM, synchronous write, registered read
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lm80c_sysram #(
	parameter int RAM_AW = 16
) (
	input  logic              CLOCK,
	input  logic [RAM_AW-1:0] addr_i,
	input  lm80c_pkg::byte_t  data_i,
	input  logic              we_i,
	output lm80c_pkg::byte_t  q_o
);

	import lm80c_pkg::*;

	byte_t mem [2**RAM_AW];                  // Maps onto block RAM

	always_ff @(posedge CLOCK) begin
		if (we_i)
			mem[addr_i] <= data_i;
		q_o <= mem[addr_i];                  // Old data on a write cycle
	end

endmodule

// File: tb_lm80c_bus.sv
//////////////////////////////////////////////////////////////
// LM80C bus glue testbench
// Random loader, CPU memory and I/O traffic against a RAM
// model, eraser run, boot signature check and DAC density
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_lm80c_bus;

	localparam int CLK_PERIOD   = 4;
	localparam int RAM_AW       = 16;
	localparam int N_LOAD       = 24;            // Random bytes after the signature
	localparam int N_MEM        = 60;
	localparam int N_IO         = 40;
	localparam int N_LED        = 10;
	localparam int N_ERASE_RD   = 20;
	localparam int N_AUDIO      = 4;
	localparam int AUDIO_CYCLES = 4096;
	localparam int ERASE_CYCLES = 2**RAM_AW;   // One address per cycle
	// Up to 6 cycles per bus access and a margin for the boot runs
	localparam int WATCHDOG_CYCLES = ERASE_CYCLES + N_AUDIO * (AUDIO_CYCLES + 4)
		+ 6 * (N_LOAD + N_MEM + N_IO + N_LED + N_ERASE_RD) + 1000;
	localparam logic [31:0] SIGNATURE = 32'h025A_C3F3;  // Address 0 in the low byte

	logic              CLOCK = 1'b0;
	logic              arst_n_i;
	logic [15:0]       cpu_addr_i;
	logic [7:0]        cpu_data_i, cpu_din_o;
	logic              cpu_rd_n_i, cpu_wr_n_i, cpu_mreq_n_i, cpu_iorq_n_i;
	logic              cpu_reset_n_o, cpu_wait_n_o;
	logic [7:0]        ctc_dout_i, vdp_dout_i, psg_dout_i;
	logic              ctc_ce_n_o, vdp_csr_n_o, vdp_csw_n_o, psg_bdir_o, psg_bc_o;
	logic              load_active_i, load_wr_i, load_done_i;
	logic [RAM_AW-1:0] load_addr_i;
	logic [7:0]        load_data_i;
	logic              erase_i, reset_key_i;
	logic [7:0]        audio_a_i, audio_b_i, audio_c_i;
	logic              led_o, audio_o;

	integer      seed = 56;
	int          errors = 0;
	int          checks = 0;
	logic [7:0]  ram_model [0:65535];          // Expected RAM contents
	bit          ram_known [0:65535];          // Written since start
	logic [15:0] known_q [$];                  // Addresses worth reading back
	logic        led_exp;

	lm80c_bus #(.RAM_AW(RAM_AW)) lm80c_bus_i (.*);

	always #(CLK_PERIOD / 2) CLOCK = ~CLOCK;

	function automatic logic [31:0] rand_word();
		rand_word = $random(seed);
	endfunction

	function automatic logic [7:0] sig_byte(input int idx);
		sig_byte = SIGNATURE[8*idx +: 8];
	endfunction

	task automatic check_byte(input string test, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s: expected %02h, actual %02h", test, exp, act);
		end
	endtask

	task automatic check_bit(input string test, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s: expected %b, actual %b", test, exp, act);
		end
	endtask

	// One loader write with the model updated alongside
	task automatic load_byte(input logic [15:0] addr, input logic [7:0] data);
		@(posedge CLOCK);
		load_active_i <= 1'b1;
		load_wr_i     <= 1'b1;
		load_addr_i   <= addr;
		load_data_i   <= data;
		if (!ram_known[addr])
			known_q.push_back(addr);
		ram_model[addr] = data;
		ram_known[addr] = 1'b1;
		@(negedge CLOCK);
		check_bit("load wait", 1'b0, cpu_wait_n_o);   // CPU stalled while loading
	endtask

	// Z80 cycle held 3 clocks and left open at the sampling point
	task automatic start_cycle(input logic [15:0] addr, input logic [7:0] data,
	                           input logic io, input logic write);
		@(posedge CLOCK);
		cpu_addr_i   <= addr;
		cpu_data_i   <= data;
		cpu_mreq_n_i <= io;
		cpu_iorq_n_i <= ~io;
		cpu_rd_n_i   <= write;
		cpu_wr_n_i   <= ~write;
		repeat (3) @(posedge CLOCK);
		@(negedge CLOCK);
	endtask

	task automatic end_cycle();
		@(posedge CLOCK);
		cpu_mreq_n_i <= 1'b1;
		cpu_iorq_n_i <= 1'b1;
		cpu_rd_n_i   <= 1'b1;
		cpu_wr_n_i   <= 1'b1;
	endtask

	// Waits for CPU wait to assert, then checks how long it stays low
	task automatic measure_wait_low(input string test, input int exp_len, input int limit);
		int n;
		n = 0;
		@(negedge CLOCK);
		while (cpu_wait_n_o === 1'b1 && n < 8) begin
			@(negedge CLOCK);
			n++;
		end
		checks++;
		if (cpu_wait_n_o !== 1'b0) begin
			errors++;
			$display("%s: CPU wait was never asserted", test);
		end else begin
			n = 0;
			while (cpu_wait_n_o === 1'b0 && n < limit) begin
				@(negedge CLOCK);
				n++;
			end
			if (n != exp_len) begin
				errors++;
				$display("** Error %s wait cycles: expected %0d, actual %0d", test, exp_len, n);
			end
		end
	endtask

	// Rewrites one signature byte under the reset key and boots again
	task automatic reload_and_boot(input string test, input int idx, input logic [7:0] data,
	                               input logic exp_led);
		@(posedge CLOCK);
		reset_key_i <= 1'b1;
		load_byte(16'(idx), data);
		@(posedge CLOCK);
		load_active_i <= 1'b0;
		load_wr_i     <= 1'b0;
		reset_key_i   <= 1'b0;
		measure_wait_low(test, 5, 20);
		check_bit(test, exp_led, led_o);
	endtask

	initial begin
		logic [31:0] r, r2;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  exp;
		logic [3:0]  grp;
		logic        io_wr;
		int          sum;
		int          ones;
		int          exp_ones;
		int          idx;

		arst_n_i      <= 1'b0;
		cpu_addr_i    <= '0;
		cpu_data_i    <= '0;
		cpu_rd_n_i    <= 1'b1;
		cpu_wr_n_i    <= 1'b1;
		cpu_mreq_n_i  <= 1'b1;
		cpu_iorq_n_i  <= 1'b1;
		ctc_dout_i    <= '0;
		vdp_dout_i    <= '0;
		psg_dout_i    <= '0;
		load_active_i <= 1'b0;
		load_wr_i     <= 1'b0;
		load_addr_i   <= '0;
		load_data_i   <= '0;
		load_done_i   <= 1'b0;
		erase_i       <= 1'b0;
		reset_key_i   <= 1'b0;
		audio_a_i     <= '0;
		audio_b_i     <= '0;
		audio_c_i     <= '0;
		repeat (4) @(posedge CLOCK);
		arst_n_i <= 1'b1;
		@(negedge CLOCK);
		check_bit("reset led", 1'b0, led_o);
		check_bit("reset audio", 1'b0, audio_o);
		check_bit("reset ctc_ce_n", 1'b1, ctc_ce_n_o);
		check_bit("reset vdp_csr_n", 1'b1, vdp_csr_n_o);
		check_bit("reset vdp_csw_n", 1'b1, vdp_csw_n_o);
		check_bit("reset psg_bdir", 1'b0, psg_bdir_o);
		check_bit("reset psg_bc", 1'b0, psg_bc_o);
		check_bit("reset cpu_reset_n", 1'b0, cpu_reset_n_o);   // Not loaded yet

		// Firmware image with the signature at 0..3 and random bytes in the ROM half
		for (int i = 0; i < 4; i++)
			load_byte(16'(i), sig_byte(i));
		for (int i = 0; i < N_LOAD; i++) begin
			r    = rand_word();
			addr = {1'b0, r[14:0]};
			if (addr < 16'd4)
				addr = addr + 16'd4;                     // Keep the signature intact
			load_byte(addr, r[23:16]);
		end
		@(posedge CLOCK);
		load_active_i <= 1'b0;
		load_wr_i     <= 1'b0;
		load_done_i   <= 1'b1;
		measure_wait_low("boot", 5, 20);
		check_bit("boot led", 1'b1, led_o);
		check_bit("boot wait", 1'b1, cpu_wait_n_o);
		check_bit("boot cpu_reset_n", 1'b1, cpu_reset_n_o);

		r    = rand_word();
		idx  = int'(r[1:0]);
		data = r[15:8];
		if (data == 8'h00)
			data = 8'h01;                                // Must really corrupt it
		reload_and_boot("bad signature", idx, sig_byte(idx) ^ data, 1'b0);
		reload_and_boot("good signature", idx, sig_byte(idx), 1'b1);
		led_exp = 1'b1;

		// CPU memory traffic where writes below 0x8000 must not land
		for (int i = 0; i < N_MEM; i++) begin
			r = rand_word();
			if (r[0]) begin
				if (r[1])
					addr = known_q[rand_word() % known_q.size()];
				else
					addr = {1'b1, r[30:16]};
				start_cycle(addr, r[15:8], 1'b0, 1'b1);
				end_cycle();
				if (addr[15]) begin
					if (!ram_known[addr])
						known_q.push_back(addr);
					ram_model[addr] = r[15:8];
					ram_known[addr] = 1'b1;
				end
			end else begin
				addr = known_q[rand_word() % known_q.size()];
				start_cycle(addr, 8'h00, 1'b0, 1'b0);
				check_byte($sformatf("memory read %04h", addr), ram_model[addr], cpu_din_o);
				end_cycle();
			end
		end

		// I/O reads and writes over the device groups 0..4
		for (int i = 0; i < N_IO; i++) begin
			r     = rand_word();
			r2    = rand_word();
			grp   = 4'(int'(r2[7:0]) % 5);
			io_wr = r2[12];
			ctc_dout_i <= r[15:8];
			vdp_dout_i <= r[23:16];
			psg_dout_i <= r[31:24];
			case (grp)
				4'h1:    exp = r[15:8];
				4'h3:    exp = r[23:16];
				4'h4:    exp = r[31:24];
				default: exp = 8'h00;                    // PIO and SIO
			endcase
			addr = {r2[31:24], grp, r2[11:8]};
			start_cycle(addr, r2[23:16], 1'b1, io_wr);
			if (!io_wr)
				check_byte($sformatf("io read %02h", addr[7:0]), exp, cpu_din_o);
			check_bit("io ctc_ce_n", grp != 4'h1, ctc_ce_n_o);
			check_bit("io vdp_csr_n", !(grp == 4'h3 && !io_wr), vdp_csr_n_o);
			check_bit("io vdp_csw_n", !(grp == 4'h3 && io_wr), vdp_csw_n_o);
			check_bit("io psg_bdir", grp == 4'h4 && io_wr, psg_bdir_o);
			check_bit("io psg_bc", grp == 4'h4 && !addr[0], psg_bc_o);
			end_cycle();
		end

		// Odd data on the LED port toggles it
		for (int i = 0; i < N_LED; i++) begin
			r = rand_word();
			start_cycle({r[15:8], 4'h7, r[3:0]}, r[23:16], 1'b1, 1'b1);
			led_exp = led_exp ^ r[16];
			check_bit("led port", led_exp, led_o);
			end_cycle();
		end

		// Eraser sweeps the whole RAM
		@(posedge CLOCK);
		erase_i <= 1'b1;
		measure_wait_low("erase", ERASE_CYCLES, ERASE_CYCLES + 100);
		@(posedge CLOCK);
		erase_i <= 1'b0;
		for (int a = 0; a < 2**RAM_AW; a++) begin
			ram_model[a] = 8'h00;
			ram_known[a] = 1'b1;
		end
		for (int i = 0; i < N_ERASE_RD; i++) begin
			r    = rand_word();
			addr = r[15:0];
			start_cycle(addr, 8'h00, 1'b0, 1'b0);
			check_byte($sformatf("erased read %04h", addr), ram_model[addr], cpu_din_o);
			end_cycle();
		end

		// Sigma-delta density over a fixed window
		for (int i = 0; i < N_AUDIO; i++) begin
			r        = rand_word();
			sum      = int'(r[7:0]) + int'(r[15:8]) + int'(r[23:16]);
			exp_ones = sum * 64 * AUDIO_CYCLES / 65536;
			@(posedge CLOCK);
			audio_a_i <= r[7:0];
			audio_b_i <= r[15:8];
			audio_c_i <= r[23:16];
			@(posedge CLOCK);                            // New sum now in the accumulator
			ones = 0;
			repeat (AUDIO_CYCLES) begin
				@(negedge CLOCK);
				if (audio_o)
					ones++;
			end
			checks++;
			if (ones < exp_ones - 1 || ones > exp_ones + 1) begin
				errors++;
				$display("** Error audio density: expected %0d, actual %0d", exp_ones, ones);
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule
